/* register_access_macros.svh */
/*
 * Register access stage constants
 * Register counts, widths, special register indices and operand codes
 */
`ifndef REGISTER_ACCESS_MACROS_SVH
`define REGISTER_ACCESS_MACROS_SVH

`define RA_NUM_GPR  8
`define RA_GPR_W    32
`define RA_SEG_W    16
`define RA_NUM_SEG  6

// General register numbers
`define RA_ESP_IDX  4
`define RA_ESI_IDX  6
`define RA_EDI_IDX  7

// Segment order is ES, CS, SS, DS, FS, GS
`define RA_CS_IDX   1
`define RA_SS_IDX   2

// Operand register taken from ModRM r/m field
`define RA_OP_MODRM 3'd4

`endif

/* register_access_pkg.sv */
/*
 * Register access stage types
 * Register words, register numbers, size and stack codes, register files
 */
`include "register_access_macros.svh"

package register_access_pkg;

    typedef logic [`RA_GPR_W-1:0] gpr_word_t;
    typedef logic [`RA_SEG_W-1:0] seg_word_t;

    typedef logic [$clog2(`RA_NUM_GPR)-1:0] reg_idx_t;

    // 1 byte, 2 word, 3 doubleword, 0 none
    typedef logic [1:0] op_size_t;

    // Bit 1 pop, bit 0 push
    typedef logic [1:0] stack_op_t;

    typedef gpr_word_t [`RA_NUM_GPR-1:0] gpr_file_t;
    typedef seg_word_t [`RA_NUM_SEG-1:0] seg_file_t;

endpackage

/* reg_wb_if.sv */
/*
 * General register writeback group
 * Number, enable, stack flag, size and data from the writeback stage
 */
interface reg_wb_if;
    import register_access_pkg::*;

    reg_idx_t  number;
    logic      en;
    logic      stack;
    op_size_t  size;
    gpr_word_t data;

    // Register file write side
    modport sink (input number, en, stack, size, data);

    // Speculative stack pointer reload
    modport observe (input en, stack, number, data);

endinterface

/* gpr_cell.sv */
/*
 * General register cell
 * One 32-bit register with byte, word or doubleword writes
 */
module gpr_cell (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  register_access_pkg::op_size_t  wr_size,
    input  register_access_pkg::gpr_word_t wr_data,
    output register_access_pkg::gpr_word_t value
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
        end else if (wr_en) begin
            case (wr_size)
                2'd1: value[7:0]  <= wr_data[7:0];
                2'd2: value[15:0] <= wr_data[15:0];
                2'd3: value       <= wr_data;
                default: ;  // size 0 leaves the register alone
            endcase
        end
    end

endmodule

/* gpr_write_decode.sv */
/*
 * General register write decoder
 * Merges writeback, MOVS steps and stack commit into one write per register
 */
`include "register_access_macros.svh"

module gpr_write_decode (
    reg_wb_if.sink                           wb,
    input  logic                             transfer,
    input  logic                             d_movs,
    input  register_access_pkg::gpr_word_t   next_esi,
    input  register_access_pkg::gpr_word_t   next_edi,
    input  logic                             wb_stack_en,
    input  register_access_pkg::gpr_word_t   commit_esp,
    output logic [`RA_NUM_GPR-1:0]           wr_en,
    output register_access_pkg::op_size_t [`RA_NUM_GPR-1:0] wr_size,
    output register_access_pkg::gpr_file_t   wr_data
);
    import register_access_pkg::*;

    // Lowest priority first so later assignments win
    always_comb begin
        for (int i = 0; i < `RA_NUM_GPR; i++) begin
            wr_en[i]   = wb.en && (wb.number == reg_idx_t'(i));
            wr_size[i] = wb.size;
            wr_data[i] = wb.data;
        end

        // MOVS only steps on an accepted instruction
        if (transfer && d_movs) begin
            wr_en[`RA_ESI_IDX]   = 1'b1;
            wr_size[`RA_ESI_IDX] = 2'd3;
            wr_data[`RA_ESI_IDX] = next_esi;
            wr_en[`RA_EDI_IDX]   = 1'b1;
            wr_size[`RA_EDI_IDX] = 2'd3;
            wr_data[`RA_EDI_IDX] = next_edi;
        end

        // Architectural ESP update from a retired stack op
        if (wb_stack_en) begin
            wr_en[`RA_ESP_IDX]   = 1'b1;
            wr_size[`RA_ESP_IDX] = 2'd3;
            wr_data[`RA_ESP_IDX] = commit_esp;
        end
    end

endmodule

/* operand_select.sv */
/*
 * Operand register select
 * Picks each operand's register from ModRM or decode and reads its value
 */
`include "register_access_macros.svh"

module operand_select (
    input  register_access_pkg::gpr_file_t gpr,
    input  logic [2:0]                     d_op0,
    input  logic [2:0]                     d_op1,
    input  register_access_pkg::reg_idx_t  d_op0_reg,
    input  register_access_pkg::reg_idx_t  d_op1_reg,
    input  logic [7:0]                     d_modrm,
    output register_access_pkg::reg_idx_t  op0_reg,
    output register_access_pkg::reg_idx_t  op1_reg,
    output register_access_pkg::gpr_word_t op0_value,
    output register_access_pkg::gpr_word_t op1_value,
    output register_access_pkg::gpr_file_t gpr_out
);

    assign gpr_out = gpr;

    // Each operand checks its own code against the ModRM form
    assign op0_reg = (d_op0 == `RA_OP_MODRM) ? d_modrm[2:0] : d_op0_reg;
    assign op1_reg = (d_op1 == `RA_OP_MODRM) ? d_modrm[2:0] : d_op1_reg;

    assign op0_value = gpr[op0_reg];
    assign op1_value = gpr[op1_reg];

endmodule

/* string_step.sv */
/*
 * MOVS index step
 * Moves ESI and EDI by the operand size, direction set by DF
 */
module string_step (
    input  register_access_pkg::gpr_word_t esi,
    input  register_access_pkg::gpr_word_t edi,
    input  logic                           flag_df,
    input  register_access_pkg::op_size_t  size,
    output register_access_pkg::gpr_word_t next_esi,
    output register_access_pkg::gpr_word_t next_edi
);
    import register_access_pkg::*;

    gpr_word_t step;

    always_comb begin
        case (size)
            2'd1:    step = gpr_word_t'(1);
            2'd2:    step = gpr_word_t'(2);
            2'd3:    step = gpr_word_t'(4);
            default: step = '0;
        endcase
    end

    // DF set walks the strings downward
    assign next_esi = flag_df ? esi - step : esi + step;
    assign next_edi = flag_df ? edi - step : edi + step;

endmodule

/* stack_tracker.sv */
/*
 * Stack pointer tracking
 * Speculative ESP for in-flight pushes and pops, the stack address,
 * and the committed ESP value for retired stack ops
 */
`include "register_access_macros.svh"

module stack_tracker (
    input  logic                            clk,
    input  logic                            rst_n,
    reg_wb_if.observe                       wb,
    input  logic                            transfer,
    input  register_access_pkg::stack_op_t  d_stack_op,
    input  register_access_pkg::op_size_t   d_size,
    input  register_access_pkg::seg_word_t  ss,
    input  register_access_pkg::gpr_word_t  esp,
    input  register_access_pkg::op_size_t   wb_stack_size,
    input  register_access_pkg::stack_op_t  wb_stack_op,
    output register_access_pkg::gpr_word_t  stack_address,
    output register_access_pkg::gpr_word_t  commit_esp
);
    import register_access_pkg::*;

    gpr_word_t spec_esp;
    gpr_word_t pop_esp;
    gpr_word_t push_esp;
    logic      esp_load;

    // Pop grows by 4 or 2, push shrinks by 4, 2 or 1
    function automatic gpr_word_t step_pointer(input gpr_word_t ptr,
                                               input logic      pop,
                                               input op_size_t  size);
        gpr_word_t result;
        if (pop) begin
            result = ptr + (size[0] ? gpr_word_t'(4) : gpr_word_t'(2));
        end else begin
            case (size)
                2'd3:    result = ptr - gpr_word_t'(4);
                2'd2:    result = ptr - gpr_word_t'(2);
                default: result = ptr - gpr_word_t'(1);
            endcase
        end
        return result;
    endfunction

    assign pop_esp  = step_pointer(spec_esp, 1'b1, d_size);
    assign push_esp = step_pointer(spec_esp, 1'b0, d_size);

    // A plain write to ESP resyncs the speculative copy
    assign esp_load = wb.en && !wb.stack && (wb.number == reg_idx_t'(`RA_ESP_IDX));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            spec_esp <= '0;
        end else if (esp_load) begin
            spec_esp <= wb.data;
        end else if (transfer && d_stack_op[1]) begin
            spec_esp <= pop_esp;
        end else if (transfer && d_stack_op[0]) begin
            spec_esp <= push_esp;
        end
    end

    // Pop reads at the current top, push writes below it
    assign stack_address = (gpr_word_t'(ss) << `RA_SEG_W)
                         + (d_stack_op[1] ? spec_esp : push_esp);

    assign commit_esp = step_pointer(esp, wb_stack_op[1], wb_stack_size);

endmodule

/* segment_regs.sv */
/*
 * Segment registers
 * ES, CS, SS, DS, FS, GS with writeback and a direct CS load
 */
`include "register_access_macros.svh"

module segment_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  register_access_pkg::reg_idx_t  wb_seg_number,
    input  logic                           wb_seg_en,
    input  register_access_pkg::seg_word_t wb_seg_data,
    input  register_access_pkg::seg_word_t write_cs,
    input  logic                           write_cs_enable,
    output register_access_pkg::seg_file_t seg
);
    import register_access_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg <= '0;
        end else begin
            // Numbers 6 and 7 match no entry and are dropped
            for (int i = 0; i < `RA_NUM_SEG; i++) begin
                if (wb_seg_en && (wb_seg_number == reg_idx_t'(i))) begin
                    seg[i] <= wb_seg_data;
                end
            end
            // Direct CS load beats a writeback to CS
            if (write_cs_enable) begin
                seg[`RA_CS_IDX] <= write_cs;
            end
        end
    end

endmodule

/* register_access_top.sv */
/*
 * Register access stage
 * Holds the general and segment registers, resolves operand registers,
 * tracks the speculative stack pointer and steps ESI/EDI for MOVS
 */
`include "register_access_macros.svh"

module register_access_top (
    input  logic                        clk,
    input  logic                        rst_n,

    // Decode side
    input  logic                        d_valid,
    output logic                        d_ready,
    input  register_access_pkg::op_size_t  d_size,
    input  logic [2:0]                  d_op0,
    input  logic [2:0]                  d_op1,
    input  register_access_pkg::reg_idx_t  d_op0_reg,
    input  register_access_pkg::reg_idx_t  d_op1_reg,
    input  logic [7:0]                  d_modrm,
    input  register_access_pkg::stack_op_t d_stack_op,
    input  logic                        d_movs,
    input  logic                        flag_df,

    // Address generation side
    output logic                        r_valid,
    input  logic                        r_ready,
    output register_access_pkg::op_size_t  r_size,
    output logic [2:0]                  r_op0,
    output logic [2:0]                  r_op1,
    output register_access_pkg::reg_idx_t  r_op0_reg,
    output register_access_pkg::reg_idx_t  r_op1_reg,
    output logic [7:0]                  r_modrm,
    output register_access_pkg::stack_op_t r_stack_op,
    output register_access_pkg::gpr_word_t r_op0_value,
    output register_access_pkg::gpr_word_t r_op1_value,
    output register_access_pkg::gpr_word_t r_stack_address,
    output register_access_pkg::gpr_file_t r_gpr,
    output register_access_pkg::seg_file_t r_seg,

    // General register writeback
    input  register_access_pkg::reg_idx_t  wb_reg_number,
    input  logic                        wb_reg_en,
    input  logic                        wb_stack,
    input  register_access_pkg::op_size_t  wb_reg_size,
    input  register_access_pkg::gpr_word_t wb_reg_data,

    // Segment register writeback
    input  register_access_pkg::reg_idx_t  wb_seg_number,
    input  logic                        wb_seg_en,
    input  register_access_pkg::seg_word_t wb_seg_data,
    input  register_access_pkg::seg_word_t write_cs,
    input  logic                        write_cs_enable,

    // Stack commit
    input  logic                        wb_stack_en,
    input  register_access_pkg::op_size_t  wb_stack_size,
    input  register_access_pkg::stack_op_t wb_stack_op
);
    import register_access_pkg::*;

    logic                       transfer;
    logic [`RA_NUM_GPR-1:0]     wr_en;
    op_size_t [`RA_NUM_GPR-1:0] wr_size;
    gpr_file_t                  wr_data;
    gpr_file_t                  cell_value;
    gpr_word_t                  next_esi;
    gpr_word_t                  next_edi;
    gpr_word_t                  commit_esp;

    reg_wb_if wb_bus ();

    // No pipe register, the handshake passes straight through
    assign r_valid  = d_valid;
    assign d_ready  = r_ready;
    assign transfer = d_valid && r_ready;

    assign r_size     = d_size;
    assign r_op0      = d_op0;
    assign r_op1      = d_op1;
    assign r_modrm    = d_modrm;
    assign r_stack_op = d_stack_op;

    assign wb_bus.number = wb_reg_number;
    assign wb_bus.en     = wb_reg_en;
    assign wb_bus.stack  = wb_stack;
    assign wb_bus.size   = wb_reg_size;
    assign wb_bus.data   = wb_reg_data;

    gpr_write_decode i_gpr_write_decode (
        .wb          (wb_bus),
        .transfer    (transfer),
        .d_movs      (d_movs),
        .next_esi    (next_esi),
        .next_edi    (next_edi),
        .wb_stack_en (wb_stack_en),
        .commit_esp  (commit_esp),
        .wr_en       (wr_en),
        .wr_size     (wr_size),
        .wr_data     (wr_data)
    );

    for (genvar i = 0; i < `RA_NUM_GPR; i++) begin : g_gpr
        gpr_cell i_gpr_cell (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (wr_en[i]),
            .wr_size (wr_size[i]),
            .wr_data (wr_data[i]),
            .value   (cell_value[i])
        );
    end

    operand_select i_operand_select (
        .gpr       (cell_value),
        .d_op0     (d_op0),
        .d_op1     (d_op1),
        .d_op0_reg (d_op0_reg),
        .d_op1_reg (d_op1_reg),
        .d_modrm   (d_modrm),
        .op0_reg   (r_op0_reg),
        .op1_reg   (r_op1_reg),
        .op0_value (r_op0_value),
        .op1_value (r_op1_value),
        .gpr_out   (r_gpr)
    );

    string_step i_string_step (
        .esi      (cell_value[`RA_ESI_IDX]),
        .edi      (cell_value[`RA_EDI_IDX]),
        .flag_df  (flag_df),
        .size     (d_size),
        .next_esi (next_esi),
        .next_edi (next_edi)
    );

    stack_tracker i_stack_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb            (wb_bus),
        .transfer      (transfer),
        .d_stack_op    (d_stack_op),
        .d_size        (d_size),
        .ss            (r_seg[`RA_SS_IDX]),
        .esp           (cell_value[`RA_ESP_IDX]),
        .wb_stack_size (wb_stack_size),
        .wb_stack_op   (wb_stack_op),
        .stack_address (r_stack_address),
        .commit_esp    (commit_esp)
    );

    segment_regs i_segment_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_seg_number   (wb_seg_number),
        .wb_seg_en       (wb_seg_en),
        .wb_seg_data     (wb_seg_data),
        .write_cs        (write_cs),
        .write_cs_enable (write_cs_enable),
        .seg             (r_seg)
    );

endmodule

/* register_access_tb.sv */
/*
 * Register access stage testbench
 * Random decode and writeback traffic checked against a reference model
 */
`include "register_access_macros.svh"

module register_access_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import register_access_pkg::*;

    localparam int EDGE_TIMEOUT_NS = 200;

    logic      clk;
    logic      rst_n;
    logic      d_valid, d_ready, d_movs, flag_df;
    op_size_t  d_size, r_size;
    logic [2:0] d_op0, d_op1, r_op0, r_op1;
    reg_idx_t  d_op0_reg, d_op1_reg, r_op0_reg, r_op1_reg;
    logic [7:0] d_modrm, r_modrm;
    stack_op_t d_stack_op, r_stack_op;
    logic      r_valid, r_ready;
    gpr_word_t r_op0_value, r_op1_value, r_stack_address;
    gpr_file_t r_gpr;
    seg_file_t r_seg;
    reg_idx_t  wb_reg_number, wb_seg_number;
    logic      wb_reg_en, wb_stack, wb_seg_en, write_cs_enable, wb_stack_en;
    op_size_t  wb_reg_size, wb_stack_size;
    gpr_word_t wb_reg_data;
    seg_word_t wb_seg_data, write_cs;
    stack_op_t wb_stack_op;

    // Reference model state
    gpr_word_t ref_gpr [`RA_NUM_GPR];
    seg_word_t ref_seg [`RA_NUM_SEG];
    gpr_word_t ref_spec_esp;

    int unsigned edge_count = 0;

    register_access_top i_register_access_top (
        .clk (clk), .rst_n (rst_n),
        .d_valid (d_valid), .d_ready (d_ready), .d_size (d_size),
        .d_op0 (d_op0), .d_op1 (d_op1), .d_op0_reg (d_op0_reg), .d_op1_reg (d_op1_reg),
        .d_modrm (d_modrm), .d_stack_op (d_stack_op), .d_movs (d_movs), .flag_df (flag_df),
        .r_valid (r_valid), .r_ready (r_ready), .r_size (r_size),
        .r_op0 (r_op0), .r_op1 (r_op1), .r_op0_reg (r_op0_reg), .r_op1_reg (r_op1_reg),
        .r_modrm (r_modrm), .r_stack_op (r_stack_op),
        .r_op0_value (r_op0_value), .r_op1_value (r_op1_value),
        .r_stack_address (r_stack_address), .r_gpr (r_gpr), .r_seg (r_seg),
        .wb_reg_number (wb_reg_number), .wb_reg_en (wb_reg_en), .wb_stack (wb_stack),
        .wb_reg_size (wb_reg_size), .wb_reg_data (wb_reg_data),
        .wb_seg_number (wb_seg_number), .wb_seg_en (wb_seg_en), .wb_seg_data (wb_seg_data),
        .write_cs (write_cs), .write_cs_enable (write_cs_enable),
        .wb_stack_en (wb_stack_en), .wb_stack_size (wb_stack_size), .wb_stack_op (wb_stack_op)
    );

    always #50 clk = ~clk;

    // Rising edge count for the polled waits
    always @(posedge clk) edge_count <= edge_count + 1;

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic wait_rising_edge;
        int unsigned start;
        int unsigned waited;
        start  = edge_count;
        waited = 0;
        while (edge_count == start && waited < EDGE_TIMEOUT_NS) begin
            #1;
            waited++;
        end
        if (edge_count == start) begin
            $display("Timeout: no rising clock edge within %0d ns", EDGE_TIMEOUT_NS);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Clock stopped");
        end
    endtask

    function automatic gpr_word_t merge_sized(input gpr_word_t old, input gpr_word_t data,
                                              input op_size_t size);
        case (size)
            2'd1:    return {old[31:8], data[7:0]};
            2'd2:    return {old[31:16], data[15:0]};
            2'd3:    return data;
            default: return old;
        endcase
    endfunction

    // Sizes 1 and 3 pop four bytes, sizes 0 and 2 pop two
    function automatic gpr_word_t pop_step(input op_size_t size);
        return (size == 2'd1 || size == 2'd3) ? 32'd4 : 32'd2;
    endfunction

    function automatic gpr_word_t push_step(input op_size_t size);
        return (size == 2'd3) ? 32'd4 : (size == 2'd2) ? 32'd2 : 32'd1;
    endfunction

    function automatic gpr_word_t string_delta(input op_size_t size);
        return (size == 2'd3) ? 32'd4 : gpr_word_t'(size);
    endfunction

    // Idle, writes, operands, MOVS, stack, everything mixed
    function automatic int cycles_in_phase(input int phase);
        case (phase)
            0:       return 20;
            1:       return 150;
            2:       return 100;
            3:       return 100;
            4:       return 150;
            default: return 200;
        endcase
    endfunction

    task automatic drive_random(input int phase);
        logic stack_phase;
        stack_phase     = (phase == 4) || (phase == 5);
        d_valid         = 1'($urandom_range(0, 1));
        r_ready         = 1'($urandom_range(0, 1));
        d_size          = op_size_t'($urandom_range(0, 3));
        d_op0           = 3'($urandom_range(0, 7));
        d_op1           = 3'($urandom_range(0, 7));
        d_op0_reg       = reg_idx_t'($urandom_range(0, 7));
        d_op1_reg       = reg_idx_t'($urandom_range(0, 7));
        d_modrm         = 8'($urandom);
        d_stack_op      = stack_phase ? stack_op_t'($urandom_range(0, 3)) : 2'd0;
        d_movs          = (phase == 3 || phase == 5) ? ($urandom_range(0, 3) != 0) : 1'b0;
        flag_df         = 1'($urandom_range(0, 1));
        wb_reg_en       = (phase == 1 || stack_phase) ? 1'($urandom_range(0, 1)) : 1'b0;
        // Steer writebacks at ESP so they meet stack commits
        if (phase == 4 && $urandom_range(0, 1) != 0) begin
            wb_reg_number = reg_idx_t'(`RA_ESP_IDX);
        end else begin
            wb_reg_number = reg_idx_t'($urandom_range(0, 7));
        end
        wb_stack        = 1'($urandom_range(0, 1));
        wb_reg_size     = op_size_t'($urandom_range(0, 3));
        wb_reg_data     = $urandom;
        wb_seg_en       = (phase == 1 || phase == 5) ? 1'($urandom_range(0, 1)) : 1'b0;
        wb_seg_number   = reg_idx_t'($urandom_range(0, 7));
        wb_seg_data     = 16'($urandom);
        write_cs        = 16'($urandom);
        write_cs_enable = (phase == 1 || phase == 5) ? ($urandom_range(0, 3) == 0) : 1'b0;
        wb_stack_en     = stack_phase ? 1'($urandom_range(0, 1)) : 1'b0;
        wb_stack_size   = op_size_t'($urandom_range(0, 3));
        wb_stack_op     = stack_op_t'($urandom_range(0, 3));
    endtask

    task automatic check_outputs;
        reg_idx_t  op0_idx;
        reg_idx_t  op1_idx;
        gpr_word_t address;
        op0_idx = (d_op0 == `RA_OP_MODRM) ? d_modrm[2:0] : d_op0_reg;
        op1_idx = (d_op1 == `RA_OP_MODRM) ? d_modrm[2:0] : d_op1_reg;
        address = {ref_seg[`RA_SS_IDX], 16'h0000}
                + (d_stack_op[1] ? ref_spec_esp : ref_spec_esp - push_step(d_size));
        check_value("r_valid", r_valid, d_valid);
        check_value("d_ready", d_ready, r_ready);
        check_value("r_size", r_size, d_size);
        check_value("r_op0", r_op0, d_op0);
        check_value("r_op1", r_op1, d_op1);
        check_value("r_modrm", r_modrm, d_modrm);
        check_value("r_stack_op", r_stack_op, d_stack_op);
        check_value("r_op0_reg", r_op0_reg, op0_idx);
        check_value("r_op1_reg", r_op1_reg, op1_idx);
        check_value("r_op0_value", r_op0_value, ref_gpr[op0_idx]);
        check_value("r_op1_value", r_op1_value, ref_gpr[op1_idx]);
        check_value("r_stack_address", r_stack_address, address);
        for (int i = 0; i < `RA_NUM_GPR; i++) begin
            check_value($sformatf("r_gpr[%0d]", i), r_gpr[i], ref_gpr[i]);
        end
        for (int i = 0; i < `RA_NUM_SEG; i++) begin
            check_value($sformatf("r_seg[%0d]", i), r_seg[i], ref_seg[i]);
        end
    endtask

    // Lowest priority first, so later writes overwrite earlier ones
    task automatic update_model;
        gpr_word_t next_gpr [`RA_NUM_GPR];
        logic      transfer;
        transfer = d_valid && r_ready;
        for (int i = 0; i < `RA_NUM_GPR; i++) begin
            next_gpr[i] = ref_gpr[i];
        end
        if (wb_reg_en) begin
            next_gpr[wb_reg_number] = merge_sized(ref_gpr[wb_reg_number], wb_reg_data,
                                                  wb_reg_size);
        end
        if (transfer && d_movs) begin
            next_gpr[`RA_ESI_IDX] = flag_df ? ref_gpr[`RA_ESI_IDX] - string_delta(d_size)
                                            : ref_gpr[`RA_ESI_IDX] + string_delta(d_size);
            next_gpr[`RA_EDI_IDX] = flag_df ? ref_gpr[`RA_EDI_IDX] - string_delta(d_size)
                                            : ref_gpr[`RA_EDI_IDX] + string_delta(d_size);
        end
        if (wb_stack_en) begin
            next_gpr[`RA_ESP_IDX] = wb_stack_op[1]
                                  ? ref_gpr[`RA_ESP_IDX] + pop_step(wb_stack_size)
                                  : ref_gpr[`RA_ESP_IDX] - push_step(wb_stack_size);
        end
        if (wb_seg_en && wb_seg_number < `RA_NUM_SEG) begin
            ref_seg[wb_seg_number] = wb_seg_data;
        end
        if (write_cs_enable) begin
            ref_seg[`RA_CS_IDX] = write_cs;
        end
        if (wb_reg_en && !wb_stack && wb_reg_number == `RA_ESP_IDX) begin
            ref_spec_esp = wb_reg_data;
        end else if (transfer && d_stack_op[1]) begin
            ref_spec_esp = ref_spec_esp + pop_step(d_size);
        end else if (transfer && d_stack_op[0]) begin
            ref_spec_esp = ref_spec_esp - push_step(d_size);
        end
        for (int i = 0; i < `RA_NUM_GPR; i++) begin
            ref_gpr[i] = next_gpr[i];
        end
    endtask

    initial begin
        void'($urandom(80));
        clk   = 1'b0;
        rst_n = 1'b0;
        drive_random(0);
        d_valid = 1'b0;
        r_ready = 1'b0;
        for (int i = 0; i < `RA_NUM_GPR; i++) ref_gpr[i] = '0;
        for (int i = 0; i < `RA_NUM_SEG; i++) ref_seg[i] = '0;
        ref_spec_esp = '0;

        repeat (5) wait_rising_edge();
        #9;
        rst_n = 1'b1;

        for (int phase = 0; phase < 6; phase++) begin
            for (int cycle = 0; cycle < cycles_in_phase(phase); cycle++) begin
                wait_rising_edge();
                // Edge is seen 1 ns late, so inputs change 10 ns after it
                #9;
                drive_random(phase);
                #30;
                check_outputs();
                update_model();
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
register_access_pkg.sv
reg_wb_if.sv
gpr_cell.sv
gpr_write_decode.sv
operand_select.sv
string_step.sv
stack_tracker.sv
segment_regs.sv
register_access_top.sv
register_access_tb.sv

/* Bender.yml */
package:
  name: register_access

sources:
  - include_dirs:
      - .
    files:
      - register_access_pkg.sv
      - reg_wb_if.sv
      - gpr_cell.sv
      - gpr_write_decode.sv
      - operand_select.sv
      - string_step.sv
      - stack_tracker.sv
      - segment_regs.sv
      - register_access_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - register_access_tb.sv
